/* verilog/uart_system_config.svh */
// uart system config: word, fifo and address sizing for the host bridge
`ifndef UART_SYSTEM_CONFIG_SVH
`define UART_SYSTEM_CONFIG_SVH

`default_nettype none

// host word shape
`define UART_SYS_WORD_W				32
`define UART_SYS_BYTES_PER_WORD		4		// lsb first on the byte link

// buffering between driver and controller
`define UART_SYS_FIFO_DEPTH			4

// memory bus, byte addressable
`define UART_SYS_ADDR_W				27

`default_nettype wire

`endif

/* verilog/link_pkg.sv */
// link package: byte and word types of the host link and internal word path
`include "uart_system_config.svh"
`default_nettype none

package link_pkg;

	//////////////////////////////////////////////////////////////////////
	// host byte link
	//////////////////////////////////////////////////////////////////////

	typedef logic [7:0] link_byte_t;

	//////////////////////////////////////////////////////////////////////
	// word path between driver, fifos and controller
	//////////////////////////////////////////////////////////////////////

	typedef logic [`UART_SYS_WORD_W-1:0] link_word_t;

	// push strobe travels with its word
	typedef struct packed {
		logic		push;
		link_word_t	data;
	} word_push_t;

endpackage

`default_nettype wire

/* verilog/bus_pkg.sv */
// bus package: command opcodes, command word layout and memory bus request
`include "uart_system_config.svh"
`default_nettype none

package bus_pkg;

	// top two bits of a command header
	typedef enum logic [1:0] {
		op_nop		= 2'd0,
		op_read		= 2'd1,
		op_write	= 2'd2,
		op_clear	= 2'd3
	} bus_op_e;

	typedef struct packed {
		bus_op_e						op;
		logic [2:0]						rsvd;		// ignored, echoed back
		logic [`UART_SYS_ADDR_W-1:0]	addr;
	} cmd_header_t;

	// header or write data, depending on where the controller is
	typedef union packed {
		cmd_header_t			hdr;
		link_pkg::link_word_t	data;
	} cmd_word_u;

	typedef struct packed {
		logic							rw;			// 1 = write
		logic [`UART_SYS_ADDR_W-1:0]	addr;
		link_pkg::link_word_t			data;
	} bus_req_t;

endpackage

`default_nettype wire

/* verilog/word_fifo.sv */
// word fifo: synchronous circular buffer of link words with full and empty flags
`include "uart_system_config.svh"
`default_nettype none

module word_fifo #(
	parameter int DEPTH = `UART_SYS_FIFO_DEPTH
)(
	input  wire logic					clock_i,
	input  wire logic					rst_n_i,
	input  link_pkg::word_push_t		push_i,
	input  wire logic					pop_i,
	output link_pkg::link_word_t		data_o,
	output logic						full_o,
	output logic						empty_o
);

	import link_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	link_word_t			mem [DEPTH];
	logic [PTR_W-1:0]	wr_ptr, rd_ptr;
	logic [CNT_W-1:0]	count;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_i.push) wr_ptr <= ptr_next(wr_ptr);
			if (pop_i)       rd_ptr <= ptr_next(rd_ptr);
			if (push_i.push && !pop_i)      count <= count + 1'b1;
			else if (pop_i && !push_i.push) count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock_i) begin
		if (push_i.push) mem[wr_ptr] <= push_i.data;
	end

	assign data_o  = mem[rd_ptr];		// oldest word
	assign full_o  = (count == CNT_W'(DEPTH));
	assign empty_o = (count == '0);

endmodule

`default_nettype wire

/* verilog/byte_link_driver.sv */
// byte link driver: four-phase host byte receiver and transmitter with word packing
`include "uart_system_config.svh"
`default_nettype none

module byte_link_driver (
	input  wire logic					clock_i,
	input  wire logic					rst_n_i,
	input  wire logic					host_rx_req_i,
	input  link_pkg::link_byte_t		host_rx_data_i,
	output logic						host_rx_ack_o,
	output logic						host_tx_req_o,
	output link_pkg::link_byte_t		host_tx_data_o,
	input  wire logic					host_tx_ack_i,
	input  wire logic					rx_full_i,
	output link_pkg::word_push_t		rx_push_o,
	input  wire logic					tx_empty_i,
	input  link_pkg::link_word_t		tx_data_i,
	output logic						tx_pop_o
);

	import link_pkg::*;

	localparam int BYTES = `UART_SYS_BYTES_PER_WORD;
	localparam int CNT_W = (BYTES > 1) ? $clog2(BYTES) : 1;

	//////////////////////////////////////////////////////////////////////
	// receive half
	//////////////////////////////////////////////////////////////////////

	logic [CNT_W-1:0]	rx_cnt;
	link_word_t			rx_shift;
	logic				rx_push_q;
	logic				rx_last, rx_take;

	assign rx_last = (rx_cnt == CNT_W'(BYTES - 1));
	// last byte waits for room in the fifo
	assign rx_take = host_rx_req_i && !host_rx_ack_o && !(rx_last && rx_full_i);

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			host_rx_ack_o <= 1'b0;
			rx_cnt        <= '0;
			rx_push_q     <= 1'b0;
		end else begin
			rx_push_q <= rx_take && rx_last;
			if (rx_take) begin
				host_rx_ack_o <= 1'b1;
				rx_cnt        <= rx_last ? '0 : rx_cnt + 1'b1;
			end else if (!host_rx_req_i) begin
				host_rx_ack_o <= 1'b0;		// host released req
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (rx_take) rx_shift <= {host_rx_data_i, rx_shift[`UART_SYS_WORD_W-1:8]};
	end

	assign rx_push_o = '{push: rx_push_q, data: rx_shift};

	//////////////////////////////////////////////////////////////////////
	// transmit half
	//////////////////////////////////////////////////////////////////////

	logic [CNT_W-1:0]	tx_cnt;
	link_word_t			tx_shift;
	logic				tx_busy;
	logic				tx_last, tx_next;

	assign tx_pop_o = !tx_busy && !tx_empty_i;
	assign tx_last  = (tx_cnt == CNT_W'(BYTES - 1));
	// ack has fallen on a byte that was not the last one
	assign tx_next  = tx_busy && !host_tx_req_o && !host_tx_ack_i && !tx_last;

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			tx_busy       <= 1'b0;
			host_tx_req_o <= 1'b0;
			tx_cnt        <= '0;
		end else if (tx_pop_o) begin
			tx_busy       <= 1'b1;
			host_tx_req_o <= 1'b1;
			tx_cnt        <= '0;
		end else if (host_tx_req_o) begin
			if (host_tx_ack_i) host_tx_req_o <= 1'b0;
		end else if (tx_busy && !host_tx_ack_i) begin
			if (tx_last) begin
				tx_busy <= 1'b0;			// word done
			end else begin
				host_tx_req_o <= 1'b1;
				tx_cnt        <= tx_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (tx_pop_o)     tx_shift <= tx_data_i;
		else if (tx_next) tx_shift <= {8'h00, tx_shift[`UART_SYS_WORD_W-1:8]};
	end

	assign host_tx_data_o = tx_shift[7:0];

endmodule

`default_nettype wire

/* verilog/comm_controller.sv */
// comm controller: decodes host commands, runs memory bus transactions, queues replies
`default_nettype none

module comm_controller (
	input  wire logic					clock_i,
	input  wire logic					rst_n_i,
	input  wire logic					rx_empty_i,
	input  link_pkg::link_word_t		rx_data_i,
	output logic						rx_pop_o,
	input  wire logic					tx_full_i,
	output link_pkg::word_push_t		tx_push_o,
	output logic						req_o,
	output bus_pkg::bus_req_t			bus_req_o,
	input  wire logic					ready_i,
	input  wire logic					done_i,
	input  wire logic					valid_i,
	input  link_pkg::link_word_t		data_i,
	output logic						clear_o
);

	import link_pkg::*;
	import bus_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_fetch,		// waiting for write data word
		st_request,
		st_wait,
		st_reply,
		st_clear
	} state_e;

	state_e			state;
	cmd_word_u		cmd;
	cmd_header_t	hdr_q;			// kept for the echo
	bus_req_t		bus_req_q;
	link_word_t		reply_q;
	logic			hdr_pop, data_pop;
	logic			bus_done;

	assign cmd = rx_data_i;

	// no new command while there is no room for its reply
	assign hdr_pop  = (state == st_idle) && !rx_empty_i && !tx_full_i;
	assign data_pop = (state == st_fetch) && !rx_empty_i;
	assign rx_pop_o = hdr_pop || data_pop;

	// completion may land in the same cycle as ready
	assign bus_done = ((state == st_wait) || (state == st_request && ready_i)) &&
		((hdr_q.op == op_read) ? valid_i : done_i);

	//////////////////////////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: if (hdr_pop) begin
					case (cmd.hdr.op)
						op_read:  state <= st_request;
						op_write: state <= st_fetch;
						op_clear: state <= st_clear;
						default:  state <= st_idle;		// nop, nothing to answer
					endcase
				end
				st_fetch:   if (data_pop) state <= st_request;
				st_request: if (bus_done) state <= st_reply;
					else if (ready_i) state <= st_wait;
				st_wait:    if (bus_done) state <= st_reply;
				st_clear:   state <= st_reply;
				st_reply:   if (!tx_full_i) state <= st_idle;
				default:    state <= st_idle;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// command and reply registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock_i) begin
		if (hdr_pop) begin
			hdr_q          <= cmd.hdr;
			bus_req_q.rw   <= (cmd.hdr.op == op_write);
			bus_req_q.addr <= cmd.hdr.addr;
			bus_req_q.data <= '0;
		end
		if (data_pop) bus_req_q.data <= cmd.data;
		if (bus_done) reply_q <= (hdr_q.op == op_read) ? data_i : link_word_t'(hdr_q);
		if (state == st_clear) reply_q <= link_word_t'(hdr_q);
	end

	assign req_o     = (state == st_request);
	assign bus_req_o = bus_req_q;
	assign clear_o   = (state == st_clear);
	assign tx_push_o = '{push: (state == st_reply) && !tx_full_i, data: reply_q};

endmodule

`default_nettype wire

/* verilog/uart_system.sv */
// uart system: host byte link bridge to the memory bus, driver plus two fifos plus controller
`include "uart_system_config.svh"
`default_nettype none

module uart_system (
	input  wire logic					clock_i,
	input  wire logic					rst_n_i,
	input  wire logic					host_rx_req_i,
	input  link_pkg::link_byte_t		host_rx_data_i,
	output logic						host_rx_ack_o,
	output logic						host_tx_req_o,
	output link_pkg::link_byte_t		host_tx_data_o,
	input  wire logic					host_tx_ack_i,
	output logic						req_o,
	output bus_pkg::bus_req_t			bus_req_o,
	input  wire logic					ready_i,
	input  wire logic					done_i,
	input  wire logic					valid_i,
	input  link_pkg::link_word_t		data_i,
	output logic						clear_o
);

	import link_pkg::*;

	// host to controller
	word_push_t		rx_push;
	link_word_t		rx_data;
	logic			rx_full, rx_empty, rx_pop;

	// controller to host
	word_push_t		tx_push;
	link_word_t		tx_data;
	logic			tx_full, tx_empty, tx_pop;

	byte_link_driver driver_inst (
		.clock_i		(clock_i),
		.rst_n_i		(rst_n_i),
		.host_rx_req_i	(host_rx_req_i),
		.host_rx_data_i	(host_rx_data_i),
		.host_rx_ack_o	(host_rx_ack_o),
		.host_tx_req_o	(host_tx_req_o),
		.host_tx_data_o	(host_tx_data_o),
		.host_tx_ack_i	(host_tx_ack_i),
		.rx_full_i		(rx_full),
		.rx_push_o		(rx_push),
		.tx_empty_i		(tx_empty),
		.tx_data_i		(tx_data),
		.tx_pop_o		(tx_pop)
	);

	word_fifo #(.DEPTH(`UART_SYS_FIFO_DEPTH)) rx_fifo_inst (
		.clock_i	(clock_i),
		.rst_n_i	(rst_n_i),
		.push_i		(rx_push),
		.pop_i		(rx_pop),
		.data_o		(rx_data),
		.full_o		(rx_full),
		.empty_o	(rx_empty)
	);

	word_fifo #(.DEPTH(`UART_SYS_FIFO_DEPTH)) tx_fifo_inst (
		.clock_i	(clock_i),
		.rst_n_i	(rst_n_i),
		.push_i		(tx_push),
		.pop_i		(tx_pop),
		.data_o		(tx_data),
		.full_o		(tx_full),
		.empty_o	(tx_empty)
	);

	comm_controller comm_inst (
		.clock_i	(clock_i),
		.rst_n_i	(rst_n_i),
		.rx_empty_i	(rx_empty),
		.rx_data_i	(rx_data),
		.rx_pop_o	(rx_pop),
		.tx_full_i	(tx_full),
		.tx_push_o	(tx_push),		// replies queued for the host
		.req_o		(req_o),
		.bus_req_o	(bus_req_o),
		.ready_i	(ready_i),
		.done_i		(done_i),
		.valid_i	(valid_i),
		.data_i		(data_i),
		.clear_o	(clear_o)
	);

endmodule

`default_nettype wire

/* sim/uart_system_sva.sv */
// uart system assertions: handshake rules of the host byte link and the memory bus
`default_nettype none

module uart_system_sva (
	input  wire logic					clock_i,
	input  wire logic					rst_n_i,
	input  wire logic					host_rx_req_i,
	input  wire logic					host_rx_ack_o,
	input  wire logic					host_tx_req_o,
	input  wire logic					host_tx_ack_i,
	input  wire link_pkg::link_byte_t	host_tx_data_o,
	input  wire logic					req_o,
	input  wire bus_pkg::bus_req_t		bus_req_o,
	input  wire logic					ready_i,
	input  wire logic					clear_o
);

	timeunit 1ns;
	timeprecision 100ps;

	// request and payload held until the memory takes them
	a_bus_hold: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		req_o && !ready_i |=> req_o && $stable(bus_req_o))
		else $error("req_o or bus_req_o changed before ready_i");

	a_bus_drop: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		req_o && ready_i |=> !req_o)
		else $error("req_o still high the cycle after ready_i");

	a_rx_ack: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		$rose(host_rx_ack_o) |-> host_rx_req_i)
		else $error("host_rx_ack_o rose without host_rx_req_i");

	// byte stays on the link until the host acks it
	a_tx_hold: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		host_tx_req_o && !host_tx_ack_i |=> host_tx_req_o && $stable(host_tx_data_o))
		else $error("host_tx_req_o or host_tx_data_o changed before host_tx_ack_i");

	a_clear_one: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		clear_o |=> !clear_o)
		else $error("clear_o high for more than one cycle");

endmodule

bind uart_system uart_system_sva sva_inst (
	.clock_i		(clock_i),
	.rst_n_i		(rst_n_i),
	.host_rx_req_i	(host_rx_req_i),
	.host_rx_ack_o	(host_rx_ack_o),
	.host_tx_req_o	(host_tx_req_o),
	.host_tx_ack_i	(host_tx_ack_i),
	.host_tx_data_o	(host_tx_data_o),
	.req_o			(req_o),
	.bus_req_o		(bus_req_o),
	.ready_i		(ready_i),
	.clear_o		(clear_o)
);

`default_nettype wire

/* sim/tb_uart_system.sv */
// uart system testbench with host byte link, memory model and reply checks from a stimulus file
`include "uart_system_config.svh"
`default_nettype none

module tb_uart_system;

	timeunit 1ns;
	timeprecision 100ps;

	import link_pkg::*;
	import bus_pkg::*;

	localparam int MAX_CMDS = 64;
	localparam int BYTES    = `UART_SYS_BYTES_PER_WORD;

	logic			clock_i = 1'b0;
	logic			rst_n_i;
	logic			host_rx_req_i, host_rx_ack_o, host_tx_req_o, host_tx_ack_i;
	link_byte_t		host_rx_data_i, host_tx_data_o;
	logic			req_o, ready_i, done_i, valid_i, clear_o;
	bus_req_t		bus_req_o;
	link_word_t		data_i;

	logic [31:0]	stim [4*MAX_CMDS];		// opcode, address, data, reply per command
	link_word_t		reply_q [$];			// expected replies in command order
	bus_req_t		bus_q [$];
	link_word_t		mem [logic [`UART_SYS_ADDR_W-1:0]];
	logic [31:0]	rng_bus, rng_host;
	logic			loaded = 1'b0;
	logic			hold_acks;
	int				n_cmds, n_clears, clear_len, clear_seen;
	int				n_checks, data_errs, proto_errs;

	always #4 clock_i = ~clock_i;		// 8 ns period

	uart_system uart_system_inst (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// host side of the receive link
	//////////////////////////////////////////////////////////////////////

	task automatic send_byte(input link_byte_t b);
		@(posedge clock_i);
		host_rx_data_i <= b;
		host_rx_req_i  <= 1'b1;
		do @(posedge clock_i); while (!host_rx_ack_o);
		host_rx_req_i <= 1'b0;
		do @(posedge clock_i); while (host_rx_ack_o);
	endtask

	task automatic send_word(input link_word_t w);
		for (int i = 0; i < BYTES; i++) send_byte(w[8*i +: 8]);		// lsb first
	endtask

	task automatic send_command(input int i);
		logic [31:0]	op, addr, data;
		link_word_t		hdr;
		bus_req_t		exp_req;
		op   = stim[4*i];
		addr = stim[4*i+1];
		data = stim[4*i+2];
		hdr  = {op[1:0], 3'b000, addr[`UART_SYS_ADDR_W-1:0]};
		if (op != 32'd0) reply_q.push_back(stim[4*i+3]);		// nop gets no reply
		if (op == 32'd1 || op == 32'd2) begin
			exp_req.rw   = (op == 32'd2);
			exp_req.addr = addr[`UART_SYS_ADDR_W-1:0];
			exp_req.data = data;
			bus_q.push_back(exp_req);
		end
		if (op == 32'd3) n_clears++;
		send_word(hdr);
		if (op == 32'd2) send_word(data);
	endtask

	// host side of the transmit link takes one reply word per pass
	initial begin : host_receiver
		link_word_t got, exp;
		forever begin
			for (int i = 0; i < BYTES; i++) begin
				do @(posedge clock_i); while (host_tx_req_o !== 1'b1);
				got[8*i +: 8] = host_tx_data_o;
				rng_host = xorshift32(rng_host);
				repeat (rng_host[1:0]) @(posedge clock_i);
				while (hold_acks) @(posedge clock_i);
				host_tx_ack_i <= 1'b1;
				do @(posedge clock_i); while (host_tx_req_o !== 1'b0);
				host_tx_ack_i <= 1'b0;
			end
			n_checks++;
			if (reply_q.size() == 0) begin
				proto_errs++;
				$display("reply %h arrived at %0d ns with no command waiting for it", got, $time);
			end else begin
				exp = reply_q.pop_front();
				if (got !== exp) begin
					data_errs++;
					$display("ERROR at %0d ns: host_tx_data_o word expected %h got %h",
						$time, exp, got);
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// memory model with random ready and completion delays
	//////////////////////////////////////////////////////////////////////

	initial begin : memory_model
		bus_req_t got_req, exp_req;
		forever begin
			do @(posedge clock_i); while (req_o !== 1'b1);
			got_req = bus_req_o;
			n_checks++;
			if (bus_q.size() == 0) begin
				proto_errs++;
				$display("bus request at %0d ns with no read or write pending", $time);
			end else begin
				exp_req = bus_q.pop_front();
				if (got_req !== exp_req) begin
					data_errs++;
					$display("ERROR at %0d ns: bus_req_o expected %h got %h",
						$time, exp_req, got_req);
				end
			end
			rng_bus = xorshift32(rng_bus);
			repeat (rng_bus[1:0]) @(posedge clock_i);
			ready_i <= 1'b1;
			@(posedge clock_i);
			ready_i <= 1'b0;
			rng_bus = xorshift32(rng_bus);
			repeat (rng_bus[2:0]) @(posedge clock_i);
			if (got_req.rw) begin
				mem[got_req.addr] = got_req.data;
				done_i <= 1'b1;
			end else begin
				data_i  <= mem.exists(got_req.addr) ? mem[got_req.addr] :
					{5'h15, got_req.addr};		// unwritten words
				valid_i <= 1'b1;
			end
			@(posedge clock_i);
			done_i  <= 1'b0;
			valid_i <= 1'b0;
		end
	end

	always @(posedge clock_i) begin : clear_monitor
		if (clear_o === 1'b1) begin
			clear_len++;
		end else if (clear_len != 0) begin
			clear_seen++;
			n_checks++;
			if (clear_len != 1) begin
				data_errs++;
				$display("ERROR at %0d ns: clear_o pulse length expected 1 got %0d",
					$time, clear_len);
			end
			clear_len = 0;
		end
	end

	initial begin : watchdog
		wait (loaded);
		repeat (n_cmds * 400) @(posedge clock_i);
		$display("timeout: run did not finish within %0d cycles", n_cmds * 400);
		$display("Some tests failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin : run_tests
		int n_serial;
		rst_n_i        = 1'b0;
		host_rx_req_i  = 1'b0;
		host_rx_data_i = '0;
		host_tx_ack_i  = 1'b0;
		ready_i        = 1'b0;
		done_i         = 1'b0;
		valid_i        = 1'b0;
		data_i         = '0;
		hold_acks      = 1'b0;
		rng_bus        = 32'hc99e0f07;
		rng_host       = xorshift32(32'hc99e0f07);
		for (int i = 0; i < 4*MAX_CMDS; i++) stim[i] = '1;		// all ones marks the end
		$readmemh("sim/uart_system_stimulus.txt", stim);
		while (n_cmds < MAX_CMDS && stim[4*n_cmds] != '1) n_cmds++;
		loaded = 1'b1;

		repeat (4) @(posedge clock_i);
		rst_n_i <= 1'b1;
		@(posedge clock_i);
		n_checks++;
		if ({host_rx_ack_o, host_tx_req_o, req_o, clear_o} !== 4'b0000) begin
			data_errs++;
			$display("ERROR at %0d ns: %s expected 0000 got %b", $time,
				"host_rx_ack_o,host_tx_req_o,req_o,clear_o",
				{host_rx_ack_o, host_tx_req_o, req_o, clear_o});
		end

		// one command at a time
		n_serial = n_cmds / 2;
		for (int i = 0; i < n_serial; i++) begin
			send_command(i);
			while (reply_q.size() != 0 || bus_q.size() != 0) @(posedge clock_i);
		end

		// back to back while replies pile up behind the held acks
		hold_acks <= 1'b1;
		fork
			for (int i = n_serial; i < n_cmds; i++) send_command(i);
			begin
				repeat (300) @(posedge clock_i);
				hold_acks <= 1'b0;
			end
		join
		while (reply_q.size() != 0) @(posedge clock_i);
		repeat (50) @(posedge clock_i);		// room for a stray reply or request

		n_checks++;
		if (bus_q.size() != 0) begin
			proto_errs++;
			$display("%0d bus requests were expected but never issued", bus_q.size());
		end
		n_checks++;
		if (clear_seen != n_clears) begin
			data_errs++;
			$display("ERROR at %0d ns: clear_o pulse count expected %0d got %0d",
				$time, n_clears, clear_seen);
		end
		$display("commands %0d, checks %0d, data errors %0d, protocol errors %0d",
			n_cmds, n_checks, data_errs, proto_errs);
		if (data_errs + proto_errs == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+verilog
verilog/link_pkg.sv
verilog/bus_pkg.sv
verilog/word_fifo.sv
verilog/byte_link_driver.sv
verilog/comm_controller.sv
verilog/uart_system.sv
sim/uart_system_sva.sv
sim/tb_uart_system.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the fail message in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_uart_system -f list.f > build.log 2>&1 &&
	./obj_dir/Vtb_uart_system > sim.log 2>&1 &&
	! grep -q "Some tests failed" sim.log &&
	echo "simulation passed" ||
	{ echo "simulation failed, see build.log and sim.log"; exit 1; }

/* sim/uart_system_stimulus.txt */
// columns: opcode (0 nop, 1 read, 2 write, 3 clear), byte address, write data, expected reply
// first half runs one command at a time, second half back to back with host acks held off
2 0000010 cafef00d 80000010
1 0000010 00000000 cafef00d
2 0000024 44332211 80000024
1 0000024 00000000 44332211   // distinct bytes, lsb first on the link
3 0000100 00000000 c0000100
0 0000200 00000000 00000000   // nop, no reply
1 0000300 00000000 a8000300   // never written, fill pattern
2 7ffffff 12345678 87ffffff
2 0000040 a5a55a5a 80000040
2 0000044 0badbeef 80000044
1 0000040 00000000 a5a55a5a
0 0000048 00000000 00000000   // nop, no reply
3 0000050 00000000 c0000050
1 0000044 00000000 0badbeef
1 7ffffff 00000000 12345678
2 0000010 11223344 80000010
